/* files.f */
+incdir+verilog
verilog/loader_pkg.sv
verilog/video_pkg.sv
verilog/rom_loader.sv
verilog/rom_bank.sv
verilog/video_out.sv
verilog/arcade_shell_top.sv
tb/shell_checker.sv
tb/tb_arcade_shell.sv

/* run.sh */
#!/usr/bin/env bash
# build the arcade shell testbench with Verilator and run it
# exit status follows the testbench verdict in the simulation output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f files.f --top-module tb_arcade_shell -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -qF 'All tests passed!' \
    && echo "simulation run: pass" \
    || { echo "simulation run: fail"; exit 1; }

/* tb/shell_checker.sv */
// bound assertions for the arcade shell
// tagged write spacing, dl_wr inside the window, one-cycle sync pulses
`default_nettype none

module shell_checker (
    input logic clk_74a,
    input logic rst_n,
    input logic wr_strobe,
    input logic dl_wr,
    input logic download,
    input logic pulse_h,
    input logic pulse_v
);
    timeunit 1ns;
    timeprecision 1ps;

    // loader has no back-pressure, host keeps four cycles between words
    assert property (@(posedge clk_74a) disable iff (!rst_n)
        wr_strobe |-> !$past(wr_strobe) && !$past(wr_strobe, 2) && !$past(wr_strobe, 3))
        else $error("tagged bridge writes closer than four cycles");

    assert property (@(posedge clk_74a) disable iff (!rst_n) dl_wr |-> download)
        else $error("byte write on dl_wr outside the download window");

    // sync pulses are single cycle
    assert property (@(posedge clk_74a) disable iff (!rst_n) pulse_h |=> !pulse_h)
        else $error("video_hs high for two cycles");
    assert property (@(posedge clk_74a) disable iff (!rst_n) pulse_v |=> !pulse_v)
        else $error("video_vs high for two cycles");

endmodule

//////////////////////////////////////////////////////////////////////
// attach to the loader and the video stage
//////////////////////////////////////////////////////////////////////

bind rom_loader shell_checker u_loader_chk (
    .clk_74a   (clk_74a),
    .rst_n     (rst_n),
    .wr_strobe (tagged_wr),
    .dl_wr     (dl_wr),
    .download  (download),
    .pulse_h   (1'b0),
    .pulse_v   (1'b0)
);

bind video_out shell_checker u_video_chk (
    .clk_74a   (clk_74a),
    .rst_n     (rst_n),
    .wr_strobe (1'b0),
    .dl_wr     (1'b0),
    .download  (1'b0),
    .pulse_h   (video_hs),
    .pulse_v   (video_vs)
);

`default_nettype wire

/* tb/tb_arcade_shell.sv */
// testbench for arcade_shell_top
// download window, ROM bank readback, video output model
// reference functions, compare tasks, timeout and summary
`default_nettype none

`include "shell_defines.svh"

module tb_arcade_shell import loader_pkg::*, video_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_main = 24;
    localparam int n_sound = 8;
    localparam int n_wave = 8;
    localparam int n_bad = 4;
    localparam int video_cycles = 900;
    localparam int n_words = n_main + n_sound + n_wave;
    localparam int n_writes = n_words + 3 * n_bad;
    // five cycles per write and one per byte read
    localparam int cycle_limit = 2 * (5 * n_writes + 4 * n_words + video_cycles + 64);

    logic clk_74a;
    logic rst_n;
    logic bridge_wr;
    logic [31:0] bridge_addr;
    logic [31:0] bridge_wr_data;
    logic dataslot_requestwrite;
    logic dataslot_allcomplete;
    logic download;
    logic game_reset;
    logic [`MAIN_ROM_AW-1:0] main_rom_addr;
    rom_byte_t main_rom_data;
    logic [`SOUND_ROM_AW-1:0] sound_rom_addr;
    rom_byte_t sound_rom_data;
    logic [`WAVE_ROM_AW-1:0] wave_rom_addr;
    rom_byte_t wave_rom_data;
    logic pix_ce;
    rgb444_t core_rgb;
    logic core_hblank;
    logic core_vblank;
    logic core_hs_n;
    logic core_vs_n;
    rgb888_t video_rgb;
    logic video_de;
    logic video_hs;
    logic video_vs;

    int seed;
    int cycles;
    int rom_errors = 0;
    int video_errors = 0;
    int level_errors = 0;

    // byte model of the download space
    rom_byte_t model [rom_addr_t];
    rom_addr_t check_addrs [$];
    rom_addr_t main_bases [$];

    // video model state
    logic hbl_hist [$];
    logic exp_de;
    logic exp_hs;
    logic exp_vs;
    logic hs_low;
    logic vs_low;
    rgb888_t exp_rgb;

    arcade_shell_top u_dut (.*);

    initial begin
        clk_74a = 1'b0;
        forever #2 clk_74a = ~clk_74a;
    end

    //////////////////////////////////////////////////////////////////////
    // reference functions
    //////////////////////////////////////////////////////////////////////

    // bank of a byte address or none when dropped
    function automatic rom_region_t region_of(input rom_addr_t a);
        if (a < 25'h000_8000) return REGION_MAIN;
        if (a >= `SOUND_ROM_BASE && a < `SOUND_ROM_END) return REGION_SOUND;
        if (a >= `WAVE_ROM_BASE && a < 25'h001_0000) return REGION_WAVE;
        return REGION_NONE;
    endfunction

    // big endian with byte 0 at the top of the word
    function automatic rom_byte_t word_byte(input logic [31:0] w, input int idx);
        return w[31 - 8 * idx -: 8];
    endfunction

    function automatic rgb888_t expand_rgb(input rgb444_t p);
        rgb888_t e;
        e.r = {p.r, p.r};
        e.g = {p.g, p.g};
        e.b = {p.b, p.b};
        return e;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic compare_byte(input string name, input rom_byte_t got, input rom_byte_t exp);
        if (got !== exp) begin
            rom_errors++;
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic compare_rgb(input string name, input rgb888_t got, input rgb888_t exp);
        if (got !== exp) begin
            video_errors++;
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            level_errors++;
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus tasks
    //////////////////////////////////////////////////////////////////////

    // inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge clk_74a);
        #1;
    endtask

    // one bridge strobe then idle so words stay four cycles apart
    task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
        bridge_wr = 1'b1;
        bridge_addr = addr;
        bridge_wr_data = data;
        step();
        bridge_wr = 1'b0;
        repeat (4) step();
    endtask

    // tagged word where the model keeps only bytes that hit a bank
    task automatic download_word(input rom_addr_t base, input logic [31:0] data);
        rom_addr_t a;
        bridge_write({`ROM_ADDR_TAG, base[23:0]}, data);
        for (int i = 0; i < 4; i++) begin
            a = base + rom_addr_t'(i);
            if (region_of(a) != REGION_NONE) begin
                model[a] = word_byte(data, i);
                check_addrs.push_back(a);
            end
        end
    endtask

    // address set now and data checked after the next edge
    task automatic read_back(input rom_addr_t a);
        rom_region_t r;
        r = region_of(a);
        main_rom_addr = a[`MAIN_ROM_AW-1:0];
        sound_rom_addr = a[`SOUND_ROM_AW-1:0];
        wave_rom_addr = a[`WAVE_ROM_AW-1:0];
        step();
        case (r)
            REGION_MAIN: compare_byte("main_rom_data", main_rom_data, model[a]);
            REGION_SOUND: compare_byte("sound_rom_data", sound_rom_data, model[a]);
            default: compare_byte("wave_rom_data", wave_rom_data, model[a]);
        endcase
    endtask

    // raster of 40 pixels by 8 lines with a pixel strobe on 3 of 4 cycles
    task automatic run_video(input int n);
        int hcnt;
        int vcnt;
        logic [31:0] rnd;
        hcnt = 0;
        vcnt = 0;
        for (int c = 0; c < n; c++) begin
            rnd = $random(seed);
            pix_ce = rnd[0] | rnd[1];
            core_rgb = rnd[15:4];
            if (pix_ce) begin
                hcnt = (hcnt + 1) % 40;
                if (hcnt == 0) vcnt = (vcnt + 1) % 8;
            end
            core_hblank = (hcnt >= 30);
            core_hs_n = !(hcnt >= 32 && hcnt < 36);
            core_vblank = (vcnt >= 6);
            core_vs_n = (vcnt != 7);
            step();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // video model and compare process
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk_74a) begin
        if (!rst_n) begin
            hbl_hist.delete();
            for (int i = 0; i < `HBLANK_DELAY; i++) hbl_hist.push_back(1'b0);
            exp_de = 1'b0;
            exp_hs = 1'b0;
            exp_vs = 1'b0;
            hs_low = 1'b0;
            vs_low = 1'b0;
        end else begin
            // oldest entry is hblank from HBLANK_DELAY strobes ago
            exp_de = !(hbl_hist[0] || core_vblank);
            if (exp_de) exp_rgb = expand_rgb(core_rgb);
            exp_hs = !core_hs_n && !hs_low;
            exp_vs = !core_vs_n && !vs_low;
            hs_low = !core_hs_n;
            vs_low = !core_vs_n;
            if (pix_ce) begin
                void'(hbl_hist.pop_front());
                hbl_hist.push_back(core_hblank);
            end
        end
    end

    // outputs settled mid cycle
    always @(negedge clk_74a) begin
        if (rst_n) begin
            compare_bit("video_de", video_de, exp_de);
            compare_bit("video_hs", video_hs, exp_hs);
            compare_bit("video_vs", video_vs, exp_vs);
            if (exp_de) compare_rgb("video_rgb", video_rgb, exp_rgb);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // timeout
    //////////////////////////////////////////////////////////////////////

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk_74a);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Test failures found");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin : main_seq
        logic [31:0] rnd;
        rom_addr_t base;
        seed = 32'he3594309;
        rst_n = 1'b0;
        bridge_wr = 1'b0;
        bridge_addr = '0;
        bridge_wr_data = '0;
        dataslot_requestwrite = 1'b0;
        dataslot_allcomplete = 1'b0;
        main_rom_addr = '0;
        sound_rom_addr = '0;
        wave_rom_addr = '0;
        pix_ce = 1'b0;
        core_rgb = '0;
        core_hblank = 1'b0;
        core_vblank = 1'b0;
        core_hs_n = 1'b1;
        core_vs_n = 1'b1;

        // game reset follows rst_n
        repeat (3) begin
            step();
            compare_bit("game_reset", game_reset, 1'b1);
            compare_bit("download", download, 1'b0);
        end
        rst_n = 1'b1;
        step();
        compare_bit("game_reset", game_reset, 1'b0);
        compare_bit("download", download, 1'b0);

        // open the window and reset rises a cycle after the strobe
        dataslot_requestwrite = 1'b1;
        compare_bit("game_reset", game_reset, 1'b0);
        step();
        dataslot_requestwrite = 1'b0;
        compare_bit("game_reset", game_reset, 1'b1);
        compare_bit("download", download, 1'b1);

        for (int i = 0; i < n_main; i++) begin
            rnd = $random(seed);
            base = {11'd0, rnd[13:2], 2'b00};
            main_bases.push_back(base);
            download_word(base, $random(seed));
        end
        for (int i = 0; i < n_sound; i++) begin
            rnd = $random(seed);
            download_word(`SOUND_ROM_BASE + {13'd0, rnd[11:2], 2'b00}, $random(seed));
        end
        for (int i = 0; i < n_wave; i++) begin
            rnd = $random(seed);
            download_word(`WAVE_ROM_BASE + {17'd0, rnd[7:2], 2'b00}, $random(seed));
        end

        // untagged and unmapped writes alias main addresses
        for (int i = 0; i < n_bad; i++) begin
            base = main_bases[i];
            bridge_write({8'h20, base[23:0]}, $random(seed));
            download_word(base + 25'h000_8000, $random(seed));
        end

        // close the window
        dataslot_allcomplete = 1'b1;
        compare_bit("game_reset", game_reset, 1'b1);
        step();
        dataslot_allcomplete = 1'b0;
        compare_bit("game_reset", game_reset, 1'b0);
        compare_bit("download", download, 1'b0);

        // tagged but outside the window
        for (int i = 0; i < n_bad; i++) begin
            base = main_bases[i];
            bridge_write({`ROM_ADDR_TAG, base[23:0]}, $random(seed));
        end

        foreach (check_addrs[i]) read_back(check_addrs[i]);

        // request beats complete in the same cycle
        dataslot_requestwrite = 1'b1;
        dataslot_allcomplete = 1'b1;
        step();
        dataslot_requestwrite = 1'b0;
        dataslot_allcomplete = 1'b0;
        compare_bit("game_reset", game_reset, 1'b1);
        compare_bit("download", download, 1'b1);
        dataslot_allcomplete = 1'b1;
        step();
        dataslot_allcomplete = 1'b0;
        compare_bit("game_reset", game_reset, 1'b0);
        compare_bit("download", download, 1'b0);

        run_video(video_cycles);
        repeat (2) step();

        $display("summary: %0d rom, %0d video, %0d level mismatches",
                 rom_errors, video_errors, level_errors);
        if (rom_errors + video_errors + level_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/arcade_shell_top.sv */
// arcade_shell_top
// ROM loader feeding main, sound and wave banks,
// plus the video output stage
`default_nettype none

`include "shell_defines.svh"

module arcade_shell_top import loader_pkg::*, video_pkg::*; (
    input  logic                     clk_74a,
    input  logic                     rst_n,
    // host bridge and data slot strobes
    input  logic                     bridge_wr,
    input  logic [31:0]              bridge_addr,
    input  logic [31:0]              bridge_wr_data,
    input  logic                     dataslot_requestwrite,
    input  logic                     dataslot_allcomplete,
    output logic                     download,
    output logic                     game_reset,
    // game core ROM reads
    input  logic [`MAIN_ROM_AW-1:0]  main_rom_addr,
    output rom_byte_t                main_rom_data,
    input  logic [`SOUND_ROM_AW-1:0] sound_rom_addr,
    output rom_byte_t                sound_rom_data,
    input  logic [`WAVE_ROM_AW-1:0]  wave_rom_addr,
    output rom_byte_t                wave_rom_data,
    // game core video
    input  logic                     pix_ce,
    input  rgb444_t                  core_rgb,
    input  logic                     core_hblank,
    input  logic                     core_vblank,
    input  logic                     core_hs_n,
    input  logic                     core_vs_n,
    output rgb888_t                  video_rgb,
    output logic                     video_de,
    output logic                     video_hs,
    output logic                     video_vs
);

    // shared download write bus
    logic        dl_wr;
    rom_addr_t   dl_addr;
    rom_byte_t   dl_data;
    rom_region_t dl_region;

    rom_loader u_loader (
        .clk_74a               (clk_74a),
        .rst_n                 (rst_n),
        .bridge_wr             (bridge_wr),
        .bridge_addr           (bridge_addr),
        .bridge_wr_data        (bridge_wr_data),
        .dataslot_requestwrite (dataslot_requestwrite),
        .dataslot_allcomplete  (dataslot_allcomplete),
        .download              (download),
        .game_reset            (game_reset),
        .dl_wr                 (dl_wr),
        .dl_addr               (dl_addr),
        .dl_data               (dl_data),
        .dl_region             (dl_region)
    );

    //////////////////////////////////////////////////////////////////////
    // ROM banks
    //////////////////////////////////////////////////////////////////////

    rom_bank #(.addr_width(`MAIN_ROM_AW)) u_main_rom (
        .clk_74a (clk_74a),
        .wr_en   (dl_wr && dl_region == REGION_MAIN),
        .wr_addr (dl_addr[`MAIN_ROM_AW-1:0]),
        .wr_data (dl_data),
        .rd_addr (main_rom_addr),
        .rd_data (main_rom_data)
    );

    rom_bank #(.addr_width(`SOUND_ROM_AW)) u_sound_rom (
        .clk_74a (clk_74a),
        .wr_en   (dl_wr && dl_region == REGION_SOUND),
        .wr_addr (dl_addr[`SOUND_ROM_AW-1:0]),
        .wr_data (dl_data),
        .rd_addr (sound_rom_addr),
        .rd_data (sound_rom_data)
    );

    // low byte of 0xffxx selects the wave sample
    rom_bank #(.addr_width(`WAVE_ROM_AW)) u_wave_rom (
        .clk_74a (clk_74a),
        .wr_en   (dl_wr && dl_region == REGION_WAVE),
        .wr_addr (dl_addr[`WAVE_ROM_AW-1:0]),
        .wr_data (dl_data),
        .rd_addr (wave_rom_addr),
        .rd_data (wave_rom_data)
    );

    //////////////////////////////////////////////////////////////////////
    // video
    //////////////////////////////////////////////////////////////////////

    video_out u_video (
        .clk_74a     (clk_74a),
        .rst_n       (rst_n),
        .pix_ce      (pix_ce),
        .core_rgb    (core_rgb),
        .core_hblank (core_hblank),
        .core_vblank (core_vblank),
        .core_hs_n   (core_hs_n),
        .core_vs_n   (core_vs_n),
        .video_rgb   (video_rgb),
        .video_de    (video_de),
        .video_hs    (video_hs),
        .video_vs    (video_vs)
    );

endmodule

`default_nettype wire

/* verilog/loader_pkg.sv */
// download types
// byte, byte address and ROM region select
`default_nettype none

package loader_pkg;

    // one byte of the ROM stream
    typedef logic [7:0] rom_byte_t;

    // byte address in the download space
    // bits 24..0 of the bridge address
    typedef logic [24:0] rom_addr_t;

    // destination bank of a download byte
    // none means the byte is dropped
    typedef enum logic [1:0] {
        REGION_NONE  = 2'd0,
        REGION_MAIN  = 2'd1,
        REGION_SOUND = 2'd2,
        REGION_WAVE  = 2'd3
    } rom_region_t;

endpackage

`default_nettype wire

/* verilog/rom_bank.sv */
// rom_bank
// single clock byte memory, download write port
// and registered read port for the game core
`default_nettype none

module rom_bank import loader_pkg::*; #(
    parameter int addr_width = 8
) (
    input  logic                  clk_74a,
    input  logic                  wr_en,
    input  logic [addr_width-1:0] wr_addr,
    input  rom_byte_t             wr_data,
    input  logic [addr_width-1:0] rd_addr,
    output rom_byte_t             rd_data
);

    localparam int depth = 2 ** addr_width;

    // storage, maps onto block RAM
    rom_byte_t mem [depth];

    // download side
    always_ff @(posedge clk_74a) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // core side
    // data one cycle after the address
    always_ff @(posedge clk_74a) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* verilog/rom_loader.sv */
// rom_loader
// download window, game reset, bridge word to byte unpacking
// and region decode of each outgoing byte
`default_nettype none

`include "shell_defines.svh"

module rom_loader import loader_pkg::*; (
    input  logic        clk_74a,
    input  logic        rst_n,
    input  logic        bridge_wr,
    input  logic [31:0] bridge_addr,
    input  logic [31:0] bridge_wr_data,
    input  logic        dataslot_requestwrite,
    input  logic        dataslot_allcomplete,
    output logic        download,
    output logic        game_reset,
    output logic        dl_wr,
    output rom_addr_t   dl_addr,
    output rom_byte_t   dl_data,
    output rom_region_t dl_region
);

    localparam rom_addr_t wave_base = `WAVE_ROM_BASE;

    logic        tagged_wr;
    logic [31:0] word_q;
    rom_addr_t   base_q;
    logic [1:0]  byte_cnt;

    //////////////////////////////////////////////////////////////////////
    // download window
    //////////////////////////////////////////////////////////////////////

    // request wins over complete in the same cycle
    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            download <= 1'b0;
        end else if (dataslot_requestwrite) begin
            download <= 1'b1;
        end else if (dataslot_allcomplete) begin
            download <= 1'b0;
        end
    end

    // core held in reset while loading
    assign game_reset = !rst_n || download;

    //////////////////////////////////////////////////////////////////////
    // word to byte unpacking
    //////////////////////////////////////////////////////////////////////

    assign tagged_wr = bridge_wr && download && (bridge_addr[31:24] == `ROM_ADDR_TAG);

    // dl_wr doubles as the busy flag while byte_cnt picks the byte
    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            dl_wr    <= 1'b0;
            byte_cnt <= 2'd0;
        end else if (tagged_wr) begin
            dl_wr    <= 1'b1;
            byte_cnt <= 2'd0;
        end else if (dl_wr) begin
            // stop after the last byte
            dl_wr    <= (byte_cnt != 2'd3);
            byte_cnt <= byte_cnt + 2'd1;
        end
    end

    // latched word and base address
    always_ff @(posedge clk_74a) begin
        if (tagged_wr) begin
            word_q <= bridge_wr_data;
            base_q <= bridge_addr[24:0];
        end
    end

    assign dl_addr = base_q + rom_addr_t'(byte_cnt);

    // big endian with the msb first
    always_comb begin
        case (byte_cnt)
            2'd0:    dl_data = word_q[31:24];
            2'd1:    dl_data = word_q[23:16];
            2'd2:    dl_data = word_q[15:8];
            default: dl_data = word_q[7:0];
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // region decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (dl_addr[24:`MAIN_ROM_AW] == '0) begin
            dl_region = REGION_MAIN;
        end else if (dl_addr >= `SOUND_ROM_BASE && dl_addr < `SOUND_ROM_END) begin
            dl_region = REGION_SOUND;
        end else if (dl_addr[24:`WAVE_ROM_AW] == wave_base[24:`WAVE_ROM_AW]) begin
            // wave bank only covers its own 256 byte page
            dl_region = REGION_WAVE;
        end else begin
            dl_region = REGION_NONE;
        end
    end

endmodule

`default_nettype wire

/* verilog/shell_defines.svh */
// shared constants of the arcade shell
// bridge tag, bank sizes, region bounds, hblank delay
`ifndef SHELL_DEFINES_SVH
`define SHELL_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// bridge address decode
//////////////////////////////////////////////////////////////////////

// upper address byte marking ROM data
`define ROM_ADDR_TAG 8'h10

//////////////////////////////////////////////////////////////////////
// ROM banks
//////////////////////////////////////////////////////////////////////

// bank address widths in bytes
`define MAIN_ROM_AW 15
`define SOUND_ROM_AW 12
`define WAVE_ROM_AW 8

// region bounds in the download byte space
// main program sits below 2**MAIN_ROM_AW
`define SOUND_ROM_BASE 25'h000_E000
`define SOUND_ROM_END 25'h000_F000
`define WAVE_ROM_BASE 25'h000_FF00

// pixel strobes between core hblank and the one used for data enable
`define HBLANK_DELAY 9

`endif

/* verilog/video_out.sv */
// video_out
// hblank delay line on pixel strobes, RGB444 to RGB888,
// data enable and one-cycle sync pulses
`default_nettype none

`include "shell_defines.svh"

module video_out import video_pkg::*; (
    input  logic    clk_74a,
    input  logic    rst_n,
    input  logic    pix_ce,
    input  rgb444_t core_rgb,
    input  logic    core_hblank,
    input  logic    core_vblank,
    input  logic    core_hs_n,
    input  logic    core_vs_n,
    output rgb888_t video_rgb,
    output logic    video_de,
    output logic    video_hs,
    output logic    video_vs
);

    logic [`HBLANK_DELAY-1:0] hbl_line;
    logic                     hbl_delayed;
    logic                     hs_prev;
    logic                     vs_prev;

    //////////////////////////////////////////////////////////////////////
    // hblank delay
    //////////////////////////////////////////////////////////////////////

    // advances once per pixel
    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            hbl_line <= '0;
        end else if (pix_ce) begin
            hbl_line <= {hbl_line[`HBLANK_DELAY-2:0], core_hblank};
        end
    end

    assign hbl_delayed = hbl_line[`HBLANK_DELAY-1];

    //////////////////////////////////////////////////////////////////////
    // pixel and sync outputs
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            video_de <= 1'b0;
            video_hs <= 1'b0;
            video_vs <= 1'b0;
            hs_prev  <= 1'b0;
            vs_prev  <= 1'b0;
        end else begin
            video_de <= !(hbl_delayed || core_vblank);
            // rising edge of active sync
            video_hs <= !hs_prev && !core_hs_n;
            video_vs <= !vs_prev && !core_vs_n;
            hs_prev  <= !core_hs_n;
            vs_prev  <= !core_vs_n;
        end
    end

    // colour held through blanking
    // nibble duplicated so 4'hf maps to 8'hff
    always_ff @(posedge clk_74a) begin
        if (!(hbl_delayed || core_vblank)) begin
            video_rgb.r <= {2{core_rgb.r}};
            video_rgb.g <= {2{core_rgb.g}};
            video_rgb.b <= {2{core_rgb.b}};
        end
    end

endmodule

`default_nettype wire

/* verilog/video_pkg.sv */
// video pixel types
// core side RGB444 and scaler side RGB888
`default_nettype none

package video_pkg;

    // pixel as produced by the game core
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb444_t;

    // pixel as sent to the scaler
    // packs to r in 23:16, b in 7:0
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb888_t;

endpackage

`default_nettype wire
